//--- common/safety_settings.svh
/*
 * Cluster size and DMR pair encodings. The pair decode only covers three harts,
 * so SAFETY_NHARTS must stay at 3.
 */
`ifndef SAFETY_SETTINGS_SVH
`define SAFETY_SETTINGS_SVH

// Number of harts in the cluster
`define SAFETY_NHARTS 3

// DMR mask with harts 0 and 1 paired
`define SAFETY_PAIR_LO 3'b011

// DMR mask with harts 1 and 2 paired
`define SAFETY_PAIR_HI 3'b110

`endif

//--- common/safety_pkg.sv
/*
 * Types shared by the mode controller. The config word is read either as a
 * mode code or as its dual and variant bits.
 */
`include "safety_settings.svh"

package safety_pkg;

  // One bit per hart
  typedef logic [`SAFETY_NHARTS-1:0] hart_vec_t;

  typedef enum logic [1:0] {
    SAFE_SINGLE      = 2'b00,
    SAFE_TMR         = 2'b01,
    SAFE_DMR         = 2'b10,
    SAFE_DMR_DELAYED = 2'b11
  } safe_mode_e;

  // Variant means TMR when not dual, delayed lockstep when dual
  typedef struct packed {
    logic dual;
    logic variant;
  } safe_cfg_bits_t;

  typedef union packed {
    safe_mode_e     mode;
    safe_cfg_bits_t bits;
  } safe_cfg_u;

  typedef enum logic [2:0] {
    MODE_RESET, MODE_BOOT, MODE_IDLE, MODE_SINGLE, MODE_TMR, MODE_DMR
  } mode_state_e;

  typedef enum logic [2:0] {
    SINGLE_RESET, SINGLE_IDLE, SINGLE_START, SINGLE_RUN, SINGLE_SYNC_OFF
  } single_state_e;

  typedef enum logic [2:0] {
    TMR_RESET, TMR_IDLE, TMR_START, TMR_BOOT, TMR_SYNC, TMR_SYNCINTC, TMR_SWSYNC
  } tmr_state_e;

  typedef enum logic [3:0] {
    DMR_RESET, DMR_IDLE, DMR_START, DMR_BOOT, DMR_SYNC, DMR_STOP, DMR_INTC_REC,
    DMR_RECOVERY
  } dmr_state_e;

endpackage

//--- hw/mode_seq_fsm.sv
/*
 * General sequencer. Boots the cluster, then picks a mode from idle while
 * start is high. A mode is left only once start drops and its harts are idle.
 */
`timescale 1ns/1ps

module mode_seq_fsm (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  start_i,
  input  safety_pkg::hart_vec_t hart_wfi_i,
  input  safety_pkg::safe_cfg_u safe_cfg_i,
  input  logic                  single_busy_i,
  input  logic                  tmr_busy_i,
  input  logic                  dmr_busy_i,
  output logic                  single_go_o,
  output logic                  tmr_go_o,
  output logic                  dmr_go_o,
  output logic                  gen_boot_o,
  output logic                  single_boot_o,
  output logic                  idle_dbg_o
);
  import safety_pkg::*;

  mode_state_e state_q, state_d;

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      state_q <= MODE_RESET;
    end
    else
    begin
      state_q <= state_d;
    end
  end

  always_comb
  begin
    state_d = state_q;
    case (state_q)
      MODE_RESET:
      begin
        state_d = MODE_BOOT;
      end
      MODE_BOOT:
      begin
        if (&hart_wfi_i)
        begin
          state_d = MODE_IDLE;
        end
      end
      MODE_IDLE:
      begin
        if (start_i)
        begin
          // Both DMR codes share one mode, the variant only matters per hart
          case (safe_cfg_i.mode)
            SAFE_SINGLE: state_d = MODE_SINGLE;
            SAFE_TMR:    state_d = MODE_TMR;
            default:     state_d = MODE_DMR;
          endcase
        end
      end
      MODE_SINGLE:
      begin
        if (!start_i && !single_busy_i)
        begin
          state_d = MODE_IDLE;
        end
      end
      MODE_TMR:
      begin
        if (!start_i && !tmr_busy_i)
        begin
          state_d = MODE_IDLE;
        end
      end
      MODE_DMR:
      begin
        if (!start_i && !dmr_busy_i)
        begin
          state_d = MODE_IDLE;
        end
      end
      default:
      begin
        state_d = MODE_IDLE;
      end
    endcase
  end

  assign single_go_o   = (state_q == MODE_SINGLE) && start_i;
  assign tmr_go_o      = (state_q == MODE_TMR) && start_i;
  assign dmr_go_o      = (state_q == MODE_DMR) && start_i;
  assign gen_boot_o    = (state_q == MODE_BOOT);
  assign single_boot_o = (state_q == MODE_SINGLE);
  assign idle_dbg_o    = (state_q == MODE_IDLE);

endmodule

//--- hw/single_run_fsm.sv
/*
 * Single-mode machine. Halts the master cores for boot, then runs until the
 * software ends or start drops. The external stop waits for all harts to wake.
 */
`timescale 1ns/1ps

module single_run_fsm (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  single_go_i,
  input  logic                  start_i,
  input  logic                  end_sw_routine_i,
  input  safety_pkg::hart_vec_t master_core_i,
  input  safety_pkg::hart_vec_t halt_ack_i,
  input  safety_pkg::hart_vec_t hart_wfi_i,
  output safety_pkg::hart_vec_t halt_req_o,
  output logic                  single_busy_o
);
  import safety_pkg::*;

  single_state_e state_q, state_d;

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      state_q <= SINGLE_RESET;
    end
    else
    begin
      state_q <= state_d;
    end
  end

  always_comb
  begin
    state_d = state_q;
    case (state_q)
      SINGLE_RESET:
      begin
        state_d = SINGLE_IDLE;
      end
      SINGLE_IDLE:
      begin
        if (single_go_i && !end_sw_routine_i)
        begin
          state_d = SINGLE_START;
        end
      end
      SINGLE_START:
      begin
        // Every master must have acked, and nothing else
        if (halt_ack_i == master_core_i)
        begin
          state_d = SINGLE_RUN;
        end
      end
      SINGLE_RUN:
      begin
        if (end_sw_routine_i && (&hart_wfi_i))
        begin
          state_d = SINGLE_IDLE;
        end
        else if (!start_i && (halt_ack_i == '0) && !end_sw_routine_i)
        begin
          state_d = SINGLE_SYNC_OFF;
        end
      end
      SINGLE_SYNC_OFF:
      begin
        if (hart_wfi_i == '0)
        begin
          state_d = SINGLE_IDLE;
        end
      end
      default:
      begin
        state_d = SINGLE_IDLE;
      end
    endcase
  end

  assign halt_req_o    = (state_q == SINGLE_START) ? master_core_i : '0;
  assign single_busy_o = (state_q != SINGLE_IDLE);

endmodule

//--- hw/tmr/tmr_hart_fsm.sv
/*
 * One TMR machine per hart. A voter error starts the software resync right
 * away. All per-hart requests are OR-ed into single outputs.
 */
`timescale 1ns/1ps
`include "safety_settings.svh"

module tmr_hart_fsm (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  tmr_go_i,
  input  logic                  end_sw_routine_i,
  input  logic                  tmr_error_i,
  input  safety_pkg::hart_vec_t halt_ack_i,
  input  safety_pkg::hart_vec_t hart_wfi_i,
  input  safety_pkg::hart_vec_t hart_intc_ack_i,
  output safety_pkg::hart_vec_t halt_req_o,
  output safety_pkg::hart_vec_t swresync_o,
  output logic                  bus_req_o,
  output logic                  voter_en_o,
  output logic                  boot_o,
  output logic                  tmr_busy_o
);
  import safety_pkg::*;

  hart_vec_t bus_v, voter_v, boot_v, busy_v;

  for (genvar i = 0; i < `SAFETY_NHARTS; i++)
  begin : g_hart
    tmr_state_e state_q, state_d;

    always_ff @(posedge clk_i or negedge rst_ni)
    begin
      if (!rst_ni)
      begin
        state_q <= TMR_RESET;
      end
      else
      begin
        state_q <= state_d;
      end
    end

    always_comb
    begin
      state_d = state_q;
      case (state_q)
        TMR_RESET:
        begin
          state_d = TMR_IDLE;
        end
        TMR_IDLE:
        begin
          if (tmr_go_i)
          begin
            state_d = TMR_START;
          end
        end
        TMR_START:
        begin
          if (halt_ack_i[i])
          begin
            state_d = TMR_BOOT;
          end
        end
        TMR_BOOT:
        begin
          if (!halt_ack_i[i])
          begin
            state_d = TMR_SYNC;
          end
        end
        TMR_SYNC:
        begin
          if ((&hart_wfi_i) && end_sw_routine_i)
          begin
            state_d = TMR_IDLE;
          end
          else if (tmr_error_i)
          begin
            state_d = TMR_SYNCINTC;
          end
        end
        // Software resync, all harts ack the interrupt and then release it
        TMR_SYNCINTC:
        begin
          if (&hart_intc_ack_i)
          begin
            state_d = TMR_SWSYNC;
          end
        end
        TMR_SWSYNC:
        begin
          if (hart_intc_ack_i == '0)
          begin
            state_d = TMR_SYNC;
          end
        end
        default:
        begin
          state_d = TMR_IDLE;
        end
      endcase
    end

    assign halt_req_o[i] = (state_q == TMR_START);
    assign swresync_o[i] = (state_q == TMR_SYNCINTC) || (state_q == TMR_SWSYNC);
    assign boot_v[i]     = (state_q == TMR_START) || (state_q == TMR_BOOT);
    assign bus_v[i]      = boot_v[i] || (state_q == TMR_SYNC) || swresync_o[i];
    assign voter_v[i]    = bus_v[i];
    assign busy_v[i]     = (state_q != TMR_IDLE);
  end

  assign bus_req_o  = |bus_v;
  assign voter_en_o = |voter_v;
  assign boot_o     = |boot_v;
  assign tmr_busy_o = |busy_v;

endmodule

//--- hw/dmr/dmr_hart_fsm.sv
/*
 * One DMR machine per hart, started only for harts in the mask. Only the two
 * pair masks are decoded, any other mask watches comparator 2.
 */
`timescale 1ns/1ps
`include "safety_settings.svh"

module dmr_hart_fsm (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  dmr_go_i,
  input  safety_pkg::safe_cfg_u safe_cfg_i,
  input  safety_pkg::hart_vec_t dmr_mask_i,
  input  logic                  end_sw_routine_i,
  input  safety_pkg::hart_vec_t dmr_error_i,
  input  safety_pkg::hart_vec_t halt_ack_i,
  input  safety_pkg::hart_vec_t hart_wfi_i,
  output safety_pkg::hart_vec_t halt_req_o,
  output safety_pkg::hart_vec_t dmr_config_o,
  output safety_pkg::hart_vec_t wfi_dmr_o,
  output logic                  bus_req_o,
  output logic                  dual_mode_o,
  output logic                  delayed_o,
  output logic                  boot_o,
  output logic                  rec_o,
  output logic                  dmr_busy_o
);
  import safety_pkg::*;

  hart_vec_t active_v, boot_v, rec_v, delayed_v, busy_v;
  logic      pair_error;
  logic      delayed_cfg;
  logic      delayed_q;

  // Comparator output that belongs to the selected pair
  always_comb
  begin
    if (dmr_mask_i == `SAFETY_PAIR_LO)
    begin
      pair_error = dmr_error_i[0];
    end
    else if (dmr_mask_i == `SAFETY_PAIR_HI)
    begin
      pair_error = dmr_error_i[1];
    end
    else
    begin
      pair_error = dmr_error_i[2];
    end
  end

  assign delayed_cfg = safe_cfg_i.bits.dual & safe_cfg_i.bits.variant;

  for (genvar i = 0; i < `SAFETY_NHARTS; i++)
  begin : g_hart
    dmr_state_e state_q, state_d;

    always_ff @(posedge clk_i or negedge rst_ni)
    begin
      if (!rst_ni)
      begin
        state_q <= DMR_RESET;
      end
      else
      begin
        state_q <= state_d;
      end
    end

    always_comb
    begin
      state_d = state_q;
      case (state_q)
        DMR_RESET:    state_d = DMR_IDLE;
        DMR_IDLE:
        begin
          if (dmr_go_i && dmr_mask_i[i])
          begin
            state_d = DMR_START;
          end
        end
        DMR_START:
        begin
          if (halt_ack_i[i])
          begin
            state_d = DMR_BOOT;
          end
        end
        DMR_BOOT:
        begin
          if (!halt_ack_i[i])
          begin
            state_d = DMR_SYNC;
          end
        end
        DMR_SYNC:
        begin
          if ((&hart_wfi_i) && end_sw_routine_i)
          begin
            state_d = DMR_IDLE;
          end
          else if (pair_error)
          begin
            state_d = DMR_STOP;
          end
        end
        // Recovery, park both harts, then halt and release to resume in sync
        DMR_STOP:
        begin
          if (&hart_wfi_i)
          begin
            state_d = DMR_INTC_REC;
          end
        end
        DMR_INTC_REC:
        begin
          if (halt_ack_i[i])
          begin
            state_d = DMR_RECOVERY;
          end
        end
        DMR_RECOVERY:
        begin
          if (!halt_ack_i[i])
          begin
            state_d = DMR_SYNC;
          end
        end
        default:      state_d = DMR_IDLE;
      endcase
    end

    assign halt_req_o[i]   = (state_q == DMR_START) || (state_q == DMR_INTC_REC);
    assign dmr_config_o[i] = (state_q != DMR_IDLE);
    assign wfi_dmr_o[i]    = (state_q == DMR_STOP);
    assign boot_v[i]       = (state_q == DMR_START) || (state_q == DMR_BOOT);
    assign rec_v[i]        = (state_q == DMR_INTC_REC) || (state_q == DMR_RECOVERY);
    assign active_v[i]     = boot_v[i] || rec_v[i] || (state_q == DMR_SYNC) || wfi_dmr_o[i];
    // No delayed request while stopped for recovery
    assign delayed_v[i]    = delayed_cfg && active_v[i] && !wfi_dmr_o[i];
    assign busy_v[i]       = (state_q != DMR_IDLE);
  end

  //////////////////////////////////////////////////
  // Sticky delayed-lockstep flag
  //////////////////////////////////////////////////

  // Held until the cluster is back in single mode with all harts parked
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      delayed_q <= 1'b0;
    end
    else if ((&hart_wfi_i) && !safe_cfg_i.bits.dual && !safe_cfg_i.bits.variant)
    begin
      delayed_q <= 1'b0;
    end
    else if (|delayed_v)
    begin
      delayed_q <= 1'b1;
    end
  end

  assign delayed_o   = delayed_q | (|delayed_v);
  assign bus_req_o   = |active_v;
  assign dual_mode_o = |active_v;
  assign boot_o      = |boot_v;
  assign rec_o       = |rec_v;
  assign dmr_busy_o  = |busy_v;

endmodule

//--- hw/safety_ctrl.sv
/*
 * Mode controller for a three-hart cluster. All signals are plain levels with
 * no handshake. Mode changes only pass through idle, never live.
 */
`timescale 1ns/1ps

module safety_ctrl (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  start_i,
  input  logic                  end_sw_routine_i,
  input  logic                  tmr_error_i,
  input  safety_pkg::safe_cfg_u safe_cfg_i,
  input  safety_pkg::hart_vec_t dmr_mask_i,
  input  safety_pkg::hart_vec_t master_core_i,
  input  safety_pkg::hart_vec_t halt_ack_i,
  input  safety_pkg::hart_vec_t hart_wfi_i,
  input  safety_pkg::hart_vec_t hart_intc_ack_i,
  input  safety_pkg::hart_vec_t dmr_error_i,
  output safety_pkg::hart_vec_t interrupt_halt_o,
  output safety_pkg::hart_vec_t interrupt_swresync_o,
  output safety_pkg::hart_vec_t dmr_config_o,
  output safety_pkg::hart_vec_t wfi_dmr_o,
  output logic                  single_bus_o,
  output logic                  tmr_voter_enable_o,
  output logic                  dual_mode_o,
  output logic                  delayed_o,
  output logic                  dmr_rec_o,
  output logic                  start_boot_o,
  output logic                  en_ext_debug_req_o
);
  import safety_pkg::*;

  logic      single_go, tmr_go, dmr_go;
  logic      gen_boot, single_boot, idle_dbg;
  logic      single_busy, tmr_busy, dmr_busy;
  hart_vec_t single_halt, tmr_halt, dmr_halt;
  logic      tmr_bus, tmr_voter, tmr_boot;
  logic      dmr_bus, dmr_boot;

  mode_seq_fsm i_mode_seq (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .start_i       (start_i),
    .hart_wfi_i    (hart_wfi_i),
    .safe_cfg_i    (safe_cfg_i),
    .single_busy_i (single_busy),
    .tmr_busy_i    (tmr_busy),
    .dmr_busy_i    (dmr_busy),
    .single_go_o   (single_go),
    .tmr_go_o      (tmr_go),
    .dmr_go_o      (dmr_go),
    .gen_boot_o    (gen_boot),
    .single_boot_o (single_boot),
    .idle_dbg_o    (idle_dbg)
  );

  single_run_fsm i_single (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .single_go_i      (single_go),
    .start_i          (start_i),
    .end_sw_routine_i (end_sw_routine_i),
    .master_core_i    (master_core_i),
    .halt_ack_i       (halt_ack_i),
    .hart_wfi_i       (hart_wfi_i),
    .halt_req_o       (single_halt),
    .single_busy_o    (single_busy)
  );

  tmr_hart_fsm i_tmr (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .tmr_go_i         (tmr_go),
    .end_sw_routine_i (end_sw_routine_i),
    .tmr_error_i      (tmr_error_i),
    .halt_ack_i       (halt_ack_i),
    .hart_wfi_i       (hart_wfi_i),
    .hart_intc_ack_i  (hart_intc_ack_i),
    .halt_req_o       (tmr_halt),
    .swresync_o       (interrupt_swresync_o),
    .bus_req_o        (tmr_bus),
    .voter_en_o       (tmr_voter),
    .boot_o           (tmr_boot),
    .tmr_busy_o       (tmr_busy)
  );

  dmr_hart_fsm i_dmr (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .dmr_go_i         (dmr_go),
    .safe_cfg_i       (safe_cfg_i),
    .dmr_mask_i       (dmr_mask_i),
    .end_sw_routine_i (end_sw_routine_i),
    .dmr_error_i      (dmr_error_i),
    .halt_ack_i       (halt_ack_i),
    .hart_wfi_i       (hart_wfi_i),
    .halt_req_o       (dmr_halt),
    .dmr_config_o     (dmr_config_o),
    .wfi_dmr_o        (wfi_dmr_o),
    .bus_req_o        (dmr_bus),
    .dual_mode_o      (dual_mode_o),
    .delayed_o        (delayed_o),
    .boot_o           (dmr_boot),
    .rec_o            (dmr_rec_o),
    .dmr_busy_o       (dmr_busy)
  );

  //////////////////////////////////////////////////
  // Output merge
  //////////////////////////////////////////////////

  // Boot keeps the shared bus and voter on until all harts park in wfi
  assign single_bus_o       = gen_boot | tmr_bus | dmr_bus;
  assign tmr_voter_enable_o = gen_boot | tmr_voter;
  assign start_boot_o       = single_boot | tmr_boot | dmr_boot;
  assign interrupt_halt_o   = single_halt | tmr_halt | dmr_halt;
  assign en_ext_debug_req_o = idle_dbg;

endmodule

//--- dv/tb_safety_ctrl.sv
/*
 * Directed testbench for the mode controller. Core responses (halt ack, wfi,
 * interrupt ack) are driven directly by the tests without a core model.
 */
`timescale 1ns/1ps
`include "safety_settings.svh"

module tb_safety_ctrl;
  import safety_pkg::*;

  localparam int POLL_MAX  = 20;
  localparam int POLL_SPAN = POLL_MAX + 2;
  // Per-test cycle bounds from poll count and fixed waits
  localparam int TIMEOUT_CYCLES = 3 + (2 * POLL_SPAN + 2) + (3 * POLL_SPAN + 5)
                                + (4 * POLL_SPAN + 5) + (6 * POLL_SPAN + 9)
                                + (4 * POLL_SPAN + 5) + (8 * POLL_SPAN + 9);

  // Output selectors for polling
  localparam int V_HALT = 0, V_SWRESYNC = 1, V_CONFIG = 2, V_WFI_DMR = 3;
  localparam int B_BUS = 0, B_VOTER = 1, B_DUAL = 2, B_DELAYED = 3;
  localparam int B_REC = 4, B_BOOT = 5, B_DEBUG = 6;

  logic      clk_i, rst_ni, start_i, end_sw_routine_i, tmr_error_i;
  safe_cfg_u safe_cfg_i;
  hart_vec_t dmr_mask_i, master_core_i, halt_ack_i, hart_wfi_i;
  hart_vec_t hart_intc_ack_i, dmr_error_i;
  hart_vec_t interrupt_halt_o, interrupt_swresync_o, dmr_config_o, wfi_dmr_o;
  logic      single_bus_o, tmr_voter_enable_o, dual_mode_o, delayed_o;
  logic      dmr_rec_o, start_boot_o, en_ext_debug_req_o;
  int        checks, errors, cycle_cnt;

  safety_ctrl i_dut (.*);

  initial clk_i = 1'b0;
  always #5 clk_i = ~clk_i;

  //////////////////////////////////////////////////
  // Compare and poll helpers
  //////////////////////////////////////////////////

  task automatic check_vec(input string name, input hart_vec_t got, input hart_vec_t exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("MISMATCH %s: got 0x%h, expected 0x%h", name, got, exp);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("MISMATCH %s: got 0x%h, expected 0x%h", name, got, exp);
    end
  endtask

  function automatic hart_vec_t pick_vec(input int sel);
    case (sel)
      V_HALT:     return interrupt_halt_o;
      V_SWRESYNC: return interrupt_swresync_o;
      V_CONFIG:   return dmr_config_o;
      default:    return wfi_dmr_o;
    endcase
  endfunction

  function automatic logic pick_bit(input int sel);
    case (sel)
      B_BUS:     return single_bus_o;
      B_VOTER:   return tmr_voter_enable_o;
      B_DUAL:    return dual_mode_o;
      B_DELAYED: return delayed_o;
      B_REC:     return dmr_rec_o;
      B_BOOT:    return start_boot_o;
      default:   return en_ext_debug_req_o;
    endcase
  endfunction

  // Sample on falling edges until the value shows up or the bound runs out
  task automatic poll_vec(input int sel, input string name, input hart_vec_t exp);
    int n;
    n = 0;
    @(negedge clk_i);
    while (pick_vec(sel) !== exp && n < POLL_MAX)
    begin
      @(negedge clk_i);
      n++;
    end
    check_vec(name, pick_vec(sel), exp);
  endtask

  task automatic poll_bit(input int sel, input string name, input logic exp);
    int n;
    n = 0;
    @(negedge clk_i);
    while (pick_bit(sel) !== exp && n < POLL_MAX)
    begin
      @(negedge clk_i);
      n++;
    end
    check_bit(name, pick_bit(sel), exp);
  endtask

  // Ack the halt until the request drops, then release
  task automatic ack_halt(input hart_vec_t harts);
    @(posedge clk_i);
    halt_ack_i <= harts;
    poll_vec(V_HALT, "interrupt_halt_o", '0);
    @(posedge clk_i);
    halt_ack_i <= '0;
  endtask

  task automatic start_mode(input safe_mode_e mode, input hart_vec_t mask);
    @(posedge clk_i);
    safe_cfg_i.mode <= mode;
    dmr_mask_i      <= mask;
    hart_wfi_i      <= '0;
    start_i         <= 1'b1;
  endtask

  // End of software with all harts parked, start dropped
  task automatic return_to_idle();
    @(posedge clk_i);
    start_i          <= 1'b0;
    end_sw_routine_i <= 1'b1;
    hart_wfi_i       <= '1;
    poll_bit(B_DEBUG, "en_ext_debug_req_o", 1'b1);
    @(posedge clk_i);
    end_sw_routine_i <= 1'b0;
    @(negedge clk_i);
  endtask

  //////////////////////////////////////////////////
  // Directed tests
  //////////////////////////////////////////////////

  task automatic boot_test();
    poll_bit(B_BUS, "single_bus_o", 1'b1);
    check_bit("tmr_voter_enable_o", tmr_voter_enable_o, 1'b1);
    check_bit("en_ext_debug_req_o", en_ext_debug_req_o, 1'b0);
    @(posedge clk_i);
    hart_wfi_i <= '1;
    poll_bit(B_DEBUG, "en_ext_debug_req_o", 1'b1);
    check_bit("single_bus_o", single_bus_o, 1'b0);
    check_bit("tmr_voter_enable_o", tmr_voter_enable_o, 1'b0);
  endtask

  task automatic single_test();
    @(posedge clk_i);
    master_core_i <= 3'b001;
    start_mode(SAFE_SINGLE, '0);
    poll_vec(V_HALT, "interrupt_halt_o", 3'b001);
    check_bit("start_boot_o", start_boot_o, 1'b1);
    ack_halt(3'b001);
    return_to_idle();
    check_vec("interrupt_halt_o", interrupt_halt_o, '0);
  endtask

  task automatic tmr_start_test();
    start_mode(SAFE_TMR, '0);
    poll_vec(V_HALT, "interrupt_halt_o", 3'b111);
    check_bit("start_boot_o", start_boot_o, 1'b1);
    check_bit("tmr_voter_enable_o", tmr_voter_enable_o, 1'b1);
    ack_halt(3'b111);
    poll_bit(B_BOOT, "start_boot_o", 1'b0);
    check_bit("tmr_voter_enable_o", tmr_voter_enable_o, 1'b1);
    return_to_idle();
    check_vec("interrupt_halt_o", interrupt_halt_o, '0);
    check_vec("interrupt_swresync_o", interrupt_swresync_o, '0);
    check_bit("single_bus_o", single_bus_o, 1'b0);
    check_bit("tmr_voter_enable_o", tmr_voter_enable_o, 1'b0);
    check_bit("start_boot_o", start_boot_o, 1'b0);
  endtask

  task automatic tmr_resync_test();
    start_mode(SAFE_TMR, '0);
    poll_vec(V_HALT, "interrupt_halt_o", 3'b111);
    ack_halt(3'b111);
    poll_bit(B_BOOT, "start_boot_o", 1'b0);
    @(posedge clk_i);
    tmr_error_i <= 1'b1;
    @(posedge clk_i);
    tmr_error_i <= 1'b0;
    poll_vec(V_SWRESYNC, "interrupt_swresync_o", 3'b111);
    check_bit("tmr_voter_enable_o", tmr_voter_enable_o, 1'b1);
    @(posedge clk_i);
    hart_intc_ack_i <= '1;
    // Resync holds while the ack is still high
    repeat (2) @(negedge clk_i);
    check_vec("interrupt_swresync_o", interrupt_swresync_o, 3'b111);
    check_bit("tmr_voter_enable_o", tmr_voter_enable_o, 1'b1);
    @(posedge clk_i);
    hart_intc_ack_i <= '0;
    poll_vec(V_SWRESYNC, "interrupt_swresync_o", '0);
    check_bit("tmr_voter_enable_o", tmr_voter_enable_o, 1'b1);
    return_to_idle();
  endtask

  task automatic delayed_dmr_test();
    start_mode(SAFE_DMR_DELAYED, `SAFETY_PAIR_LO);
    poll_vec(V_HALT, "interrupt_halt_o", 3'b011);
    check_vec("dmr_config_o", dmr_config_o, 3'b011);
    check_bit("dual_mode_o", dual_mode_o, 1'b1);
    check_bit("delayed_o", delayed_o, 1'b1);
    ack_halt(3'b011);
    return_to_idle();
    check_bit("dual_mode_o", dual_mode_o, 1'b0);
    check_bit("delayed_o", delayed_o, 1'b1);
    @(posedge clk_i);
    safe_cfg_i.mode <= SAFE_SINGLE;
    poll_bit(B_DELAYED, "delayed_o", 1'b0);
  endtask

  task automatic dmr_recovery_test();
    start_mode(SAFE_DMR, `SAFETY_PAIR_HI);
    poll_vec(V_HALT, "interrupt_halt_o", 3'b110);
    ack_halt(3'b110);
    poll_bit(B_BOOT, "start_boot_o", 1'b0);
    // Comparator 0 belongs to the other pair
    @(posedge clk_i);
    dmr_error_i <= 3'b001;
    @(posedge clk_i);
    dmr_error_i <= '0;
    repeat (3) @(negedge clk_i);
    check_vec("wfi_dmr_o", wfi_dmr_o, '0);
    @(posedge clk_i);
    dmr_error_i <= 3'b010;
    @(posedge clk_i);
    dmr_error_i <= '0;
    poll_vec(V_WFI_DMR, "wfi_dmr_o", 3'b110);
    @(posedge clk_i);
    hart_wfi_i <= '1;
    poll_vec(V_HALT, "interrupt_halt_o", 3'b110);
    check_bit("dmr_rec_o", dmr_rec_o, 1'b1);
    ack_halt(3'b110);
    poll_bit(B_REC, "dmr_rec_o", 1'b0);
    return_to_idle();
  endtask

  //////////////////////////////////////////////////
  // Run control
  //////////////////////////////////////////////////

  initial
  begin
    cycle_cnt = 0;
    while (cycle_cnt < TIMEOUT_CYCLES)
    begin
      @(posedge clk_i);
      cycle_cnt++;
    end
    $display("ERROR: tests did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("*** FAILED ***");
    $finish;
  end

  initial
  begin
    checks           = 0;
    errors           = 0;
    rst_ni           = 1'b0;
    start_i          = 1'b0;
    end_sw_routine_i = 1'b0;
    tmr_error_i      = 1'b0;
    safe_cfg_i       = '0;
    dmr_mask_i       = '0;
    master_core_i    = '0;
    halt_ack_i       = '0;
    hart_wfi_i       = '0;
    hart_intc_ack_i  = '0;
    dmr_error_i      = '0;
    repeat (3) @(posedge clk_i);
    rst_ni <= 1'b1;
    boot_test();
    single_test();
    tmr_start_test();
    tmr_resync_test();
    delayed_dmr_test();
    dmr_recovery_test();
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0)
    begin
      $display("*** PASSED ***");
    end
    else
    begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

//--- vlog.f
+incdir+common
common/safety_pkg.sv
hw/mode_seq_fsm.sv
hw/single_run_fsm.sv
hw/tmr/tmr_hart_fsm.sv
hw/dmr/dmr_hart_fsm.sv
hw/safety_ctrl.sv
dv/tb_safety_ctrl.sv

//--- Bender.yml
package:
  name: safety_ctrl

sources:
  - include_dirs:
      - common
    files:
      - common/safety_pkg.sv
      - hw/mode_seq_fsm.sv
      - hw/single_run_fsm.sv
      - hw/tmr/tmr_hart_fsm.sv
      - hw/dmr/dmr_hart_fsm.sv
      - hw/safety_ctrl.sv
  - target: test
    include_dirs:
      - common
    files:
      - dv/tb_safety_ctrl.sv
